//--- sim/eccMemTrace.txt
# test op addr wdata flip expData expSingle expDouble, all hex except the test number
# op w writes with the flip mask, r reads and checks, i leaves the cycle idle
1 w 0 12345678 0 0 0 0
1 w 1 deadbeef 0 0 0 0
1 r 0 0 0 12345678 0 0
1 r 1 0 0 deadbeef 0 0
2 w 2 cafef00d 1 0 0 0
2 w 3 0badf00d 80000000 0 0 0
2 w 4 a5a5a5a5 4000000000 0 0 0
2 r 2 0 0 cafef00d 1 0
2 r 3 0 0 0badf00d 1 0
2 r 4 0 0 a5a5a5a5 1 0
3 w 5 13572468 800 0 0 0
3 r 5 0 0 13572468 1 0
3 i 0 0 0 0 0 0
3 i 0 0 0 0 0 0
3 r 5 0 0 13572468 0 0
4 w 6 ffffffff 3 0 0 0
4 w 7 01020304 100000001 0 0 0
4 r 6 0 0 0 0 1
4 r 7 0 0 0 0 1
5 w 8 11111111 4 0 0 0
5 w 9 22222222 0 0 0 0
5 w a 33333333 0 0 0 0
5 r 8 0 0 11111111 1 0
5 r 9 0 0 22222222 0 0
5 r a 0 0 33333333 0 0
5 i 0 0 0 0 0 0
5 i 0 0 0 0 0 0
5 r 8 0 0 11111111 1 0
5 i 0 0 0 0 0 0
5 i 0 0 0 0 0 0
5 r 8 0 0 11111111 0 0

//--- flist.f
design/hsiaoEccPkg.sv
design/eccMemIf.sv
design/hsiaoEccEnc.sv
design/hsiaoEccCor.sv
design/eccSram.sv
design/eccMemCtrl.sv
design/eccMemTop.sv
sim/eccMem_assertions.sv
sim/eccMemChecker.sv
sim/eccMemTb.sv

//--- run.sh
#!/bin/sh
# Builds the ECC memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module eccMemTb -f flist.f --Mdir obj_dir -o eccMemSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/eccMemSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The testbench verdict decides the script status
if grep -q "Test failed" sim.log; then
  exit 1
fi
exit 0

//--- sim/eccMemTb.sv
module eccMemTb;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned ProtWidth = 7;
  localparam int unsigned AddrWidth = 4;
  localparam int unsigned TotalWidth = DataWidth + ProtWidth;
  localparam int unsigned Depth = 2 ** AddrWidth;
  localparam int unsigned DrainLimit = 20;

  logic                  clk;
  logic                  rstN;
  logic                  reqValid;
  logic                  reqWrite;
  logic [ AddrWidth-1:0] reqAddr;
  logic [ DataWidth-1:0] reqWdata;
  logic [TotalWidth-1:0] reqFlip;
  logic                  rspValid;
  logic [ DataWidth-1:0] rspData;
  logic                  rspSingle;
  logic                  rspDouble;
  logic [ ProtWidth-1:0] rspSyndrome;
  logic [           7:0] corrCount;
  logic [           7:0] uncorrCount;
  // Expected read result that goes to the checker with each strobe
  logic [ DataWidth-1:0] expData;
  logic                  expSingle;
  logic                  expDouble;
  logic [           7:0] testId;
  logic                  testEnd;
  logic                  runEnd;
  int                    pending;
  int                    errCount;
  logic [          31:0] lfsrState;
  logic [ DataWidth-1:0] fillWords [Depth];

  always #5 clk = ~clk;

  eccMemTop #(
    .DataWidth (DataWidth),
    .ProtWidth (ProtWidth),
    .AddrWidth (AddrWidth)
  ) eccMemTop_i (
    .clk, .rstN,
    .reqValid, .reqWrite, .reqAddr, .reqWdata, .reqFlip,
    .rspValid, .rspData, .rspSingle, .rspDouble, .rspSyndrome,
    .corrCount, .uncorrCount
  );

  // The checker sees the same request strobes as the DUT
  eccMemChecker #(
    .DataWidth (DataWidth),
    .ProtWidth (ProtWidth)
  ) eccMemChecker_i (
    .clk, .rstN, .reqValid, .reqWrite,
    .expData, .expSingle, .expDouble, .testId, .testEnd, .runEnd,
    .rspValid, .rspData, .rspSingle, .rspDouble, .rspSyndrome,
    .corrCount, .uncorrCount, .pending, .errCount
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrStep(logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // One LFSR step per bit of the word
  task automatic nextFillWord(output logic [DataWidth-1:0] word);
    for (int i = 0; i < DataWidth; i++) begin
      lfsrState = lfsrStep(lfsrState);
      word[i] = lfsrState[31];
    end
  endtask

  // Applies one cycle of stimulus at the falling edge
  task automatic drive(input logic valid, input logic write, input logic [AddrWidth-1:0] addr,
                       input logic [DataWidth-1:0] data, input logic [TotalWidth-1:0] mask,
                       input logic [DataWidth-1:0] eData, input logic eSingle,
                       input logic eDouble);
    @(negedge clk);
    reqValid = valid;
    reqWrite = write;
    reqAddr = addr;
    reqWdata = data;
    reqFlip = mask;
    expData = eData;
    expSingle = eSingle;
    expDouble = eDouble;
  endtask

  // Goes idle, lets outstanding reads drain, then tells the checker the test is over
  // drained comes back low when reads are still open after the drain limit
  task automatic endTest(output logic drained);
    int waited;
    drive(1'b0, 1'b0, '0, '0, '0, '0, 1'b0, 1'b0);
    waited = 0;
    while (pending != 0 && waited < DrainLimit) begin
      @(negedge clk);
      waited++;
    end
    drained = (pending == 0);
    if (!drained) begin
      $display("Reads still outstanding %0d cycles after the end of test %0d",
               DrainLimit, testId);
    end else begin
      testEnd = 1'b1;
      @(negedge clk);
      testEnd = 1'b0;
    end
  endtask

  initial begin
    int fd;
    int code;
    int testNum;
    int curTest;
    logic drained;
    string line;
    byte op;
    logic [ AddrWidth-1:0] tAddr;
    logic [ DataWidth-1:0] tData;
    logic [TotalWidth-1:0] tFlip;
    logic [ DataWidth-1:0] tExp;
    logic                  tSingle;
    logic                  tDouble;
    clk = 1'b0;
    rstN = 1'b0;
    reqValid = 1'b0;
    reqWrite = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    reqFlip = '0;
    expData = '0;
    expSingle = 1'b0;
    expDouble = 1'b0;
    testId = '0;
    testEnd = 1'b0;
    runEnd = 1'b0;
    lfsrState = 32'hbe19;
    curTest = 0;
    drained = 1'b1;
    repeat (3) @(negedge clk);
    rstN = 1'b1;

    // Tests 1 to 5 come from the trace with one line per cycle
    fd = $fopen("sim/eccMemTrace.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the trace file");
      $display("Test failed");
      $finish;
    end else begin
      while (!$feof(fd) && drained) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%d %c %h %h %h %h %h %h", testNum, op, tAddr, tData, tFlip,
                         tExp, tSingle, tDouble);
          // A new test number closes the previous test first
          if (curTest != 0 && testNum != curTest) begin
            endTest(drained);
          end
          curTest = testNum;
          testId = 8'(testNum);
          if (drained) begin
            drive(op != "i", op == "w", tAddr, tData, tFlip, tExp, tSingle, tDouble);
          end
        end
      end
      $fclose(fd);
      if (curTest != 0 && drained) begin
        endTest(drained);
      end

      // Test 6 fills every address with LFSR words and reads them all back
      if (drained) begin
        testId = 8'd6;
        for (int a = 0; a < Depth; a++) begin
          nextFillWord(fillWords[a]);
          drive(1'b1, 1'b1, AddrWidth'(a), fillWords[a], '0, '0, 1'b0, 1'b0);
        end
        for (int a = 0; a < Depth; a++) begin
          drive(1'b1, 1'b0, AddrWidth'(a), '0, '0, fillWords[a], 1'b0, 1'b0);
        end
        endTest(drained);
      end

      // The checker prints its totals on the edge after runEnd rises
      runEnd = 1'b1;
      @(negedge clk);
      runEnd = 1'b0;
      if (drained && errCount == 0) begin
        $display("Test passed");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule

//--- sim/eccMemChecker.sv
module eccMemChecker
  import hsiaoEccPkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7,
  parameter int unsigned MaxLatency = 10
) (
  input  logic                  clk,
  input  logic                  rstN,
  // Request side carries the expected read result along with each strobe
  input  logic                  reqValid,
  input  logic                  reqWrite,
  input  logic [ DataWidth-1:0] expData,
  input  logic                  expSingle,
  input  logic                  expDouble,
  // Test bookkeeping from the stimulus side
  input  logic [           7:0] testId,
  input  logic                  testEnd,
  input  logic                  runEnd,
  // DUT response
  input  logic                  rspValid,
  input  logic [ DataWidth-1:0] rspData,
  input  logic                  rspSingle,
  input  logic                  rspDouble,
  input  logic [ ProtWidth-1:0] rspSyndrome,
  input  logic [CountWidth-1:0] corrCount,
  input  logic [CountWidth-1:0] uncorrCount,
  output int                    pending,
  output int                    errCount
);

  // One outstanding read and the cycle of its strobe
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic                 single;
    logic                 dbl;
    int                   issued;
  } expT;

  expT expQ[$];
  int cycle = 0;
  int queued = 0;
  int errors = 0;
  int testChecks = 0;
  int testErrors = 0;
  int totalChecks = 0;
  int testCount = 0;
  // Expected counter values that stop at all ones
  logic [CountWidth-1:0] expCorr = '0;
  logic [CountWidth-1:0] expUncorr = '0;

  assign pending = queued;
  assign errCount = errors;

  task automatic countError();
    testErrors++;
    errors++;
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
    testChecks++;
    if (got !== want) begin
      $display("** Error: %s is 0x%0h, expected 0x%0h", name, got, want);
      countError();
    end
  endtask

  always @(posedge clk) begin
    expT head;
    expT entry;
    cycle++;
    if (rstN) begin
      if (rspValid && expQ.size() == 0) begin
        $display("A response arrived with no read outstanding");
        countError();
      end else if (rspValid) begin
        head = expQ.pop_front();
        checkValue("rspLatency", 64'(cycle - head.issued), 64'd2);
        // Uncorrectable data is meaningless
        if (!head.dbl) begin
          checkValue("rspData", 64'(rspData), 64'(head.data));
        end
        checkValue("rspSingle", 64'(rspSingle), 64'(head.single));
        checkValue("rspDouble", 64'(rspDouble), 64'(head.dbl));
        if (head.single || head.dbl) begin
          testChecks++;
          if (rspSyndrome == '0) begin
            $display("** Error: rspSyndrome is 0x0, expected a nonzero value");
            countError();
          end
        end else begin
          checkValue("rspSyndrome", 64'(rspSyndrome), 64'h0);
        end
        // The DUT counters move on the same edge that raises rspValid
        if (head.single && expCorr != '1) expCorr++;
        if (head.dbl && expUncorr != '1) expUncorr++;
        checkValue("corrCount", 64'(corrCount), 64'(expCorr));
        checkValue("uncorrCount", 64'(uncorrCount), 64'(expUncorr));
      end
      if (expQ.size() != 0 && cycle - expQ[0].issued > MaxLatency) begin
        $display("No response within %0d cycles of a read strobe", MaxLatency);
        countError();
        void'(expQ.pop_front());
      end
      if (reqValid && !reqWrite) begin
        entry.data = expData;
        entry.single = expSingle;
        entry.dbl = expDouble;
        entry.issued = cycle;
        expQ.push_back(entry);
      end
      if (testEnd) begin
        $display("test %0d finished: %0d checks, %0d errors", testId, testChecks, testErrors);
        totalChecks += testChecks;
        testCount++;
        testChecks = 0;
        testErrors = 0;
      end
      if (runEnd) begin
        $display("%0d tests, %0d checks, %0d errors", testCount, totalChecks, errors);
      end
    end
    queued = expQ.size();
  end

endmodule

//--- sim/eccMem_assertions.sv
module eccMem_assertions (
  input logic clk,
  input logic rstN,
  input logic reqValid,
  input logic reqWrite,
  input logic rspValid,
  input logic rspSingle,
  input logic rspDouble,
  input logic memEn,
  input logic memWe
);

  // A response is either corrected or uncorrectable and never both
  flagsExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(rspSingle && rspDouble))
    else $error("rspSingle and rspDouble high in the same cycle");

  // Every read strobe gives a response two cycles later and nothing else does
  readLatency: assert property (@(posedge clk) disable iff (!rstN)
    rspValid == $past(reqValid && !reqWrite, 2))
    else $error("rspValid does not line up with a read strobe two cycles back");

  // A corrected response scrubs its word back unless a request takes the array
  writeBackIssued: assert property (@(posedge clk) disable iff (!rstN)
    (rspValid && rspSingle && !reqValid) |-> (memEn && memWe))
    else $error("no array write-back for a corrected response in a free cycle");

endmodule

bind eccMemCtrl eccMem_assertions eccMem_assertions_i (
  .clk,
  .rstN,
  .reqValid,
  .reqWrite,
  .rspValid,
  .rspSingle,
  .rspDouble,
  .memEn (mem.memEn),
  .memWe (mem.memWe)
);

//--- design/eccMemTop.sv
module eccMemTop
  import hsiaoEccPkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7,
  parameter int unsigned AddrWidth = 4,
  localparam int unsigned TotalWidth = DataWidth + ProtWidth
) (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  reqValid,
  input  logic                  reqWrite,
  input  logic [ AddrWidth-1:0] reqAddr,
  input  logic [ DataWidth-1:0] reqWdata,
  input  logic [TotalWidth-1:0] reqFlip,
  output logic                  rspValid,
  output logic [ DataWidth-1:0] rspData,
  output logic                  rspSingle,
  output logic                  rspDouble,
  output logic [ ProtWidth-1:0] rspSyndrome,
  output logic [CountWidth-1:0] corrCount,
  output logic [CountWidth-1:0] uncorrCount
);

  // Encoder and corrector hang off the controller as pure logic
  logic [ DataWidth-1:0] encData;
  logic [TotalWidth-1:0] encCode;
  logic [TotalWidth-1:0] corIn;
  logic [TotalWidth-1:0] corOut;
  logic [ ProtWidth-1:0] corSyndrome;
  logic                  corSingle;
  logic                  corDouble;

  eccMemIf #(
    .TotalWidth (TotalWidth),
    .AddrWidth  (AddrWidth)
  ) memBus ();

  eccMemCtrl #(
    .DataWidth (DataWidth),
    .ProtWidth (ProtWidth),
    .AddrWidth (AddrWidth)
  ) eccMemCtrl_i (
    .clk, .rstN,
    .reqValid, .reqWrite, .reqAddr, .reqWdata, .reqFlip,
    .rspValid, .rspData, .rspSingle, .rspDouble, .rspSyndrome,
    .corrCount, .uncorrCount,
    .mem (memBus),
    .encData, .encCode,
    .corIn, .corOut, .corSyndrome, .corSingle, .corDouble
  );

  eccSram #(
    .TotalWidth (TotalWidth),
    .AddrWidth  (AddrWidth)
  ) eccSram_i (
    .clk,
    .mem (memBus)
  );

  hsiaoEccEnc #(
    .DataWidth (DataWidth),
    .ProtWidth (ProtWidth)
  ) hsiaoEccEnc_i (
    .in  (encData),
    .out (encCode)
  );

  hsiaoEccCor #(
    .DataWidth (DataWidth),
    .ProtWidth (ProtWidth)
  ) hsiaoEccCor_i (
    .in        (corIn),
    .out       (corOut),
    .syndrome  (corSyndrome),
    .errSingle (corSingle),
    .errDouble (corDouble)
  );

endmodule

//--- design/eccMemCtrl.sv
module eccMemCtrl
  import hsiaoEccPkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7,
  parameter int unsigned AddrWidth = 4,
  localparam int unsigned TotalWidth = DataWidth + ProtWidth
) (
  input  logic                  clk,
  input  logic                  rstN,
  // Request strobe, always accepted
  input  logic                  reqValid,
  input  logic                  reqWrite,
  input  logic [ AddrWidth-1:0] reqAddr,
  input  logic [ DataWidth-1:0] reqWdata,
  input  logic [TotalWidth-1:0] reqFlip,
  // Read response
  output logic                  rspValid,
  output logic [ DataWidth-1:0] rspData,
  output logic                  rspSingle,
  output logic                  rspDouble,
  output logic [ ProtWidth-1:0] rspSyndrome,
  output logic [CountWidth-1:0] corrCount,
  output logic [CountWidth-1:0] uncorrCount,
  // Storage array
  eccMemIf.ctrl                 mem,
  // Encoder
  output logic [ DataWidth-1:0] encData,
  input  logic [TotalWidth-1:0] encCode,
  // Corrector
  output logic [TotalWidth-1:0] corIn,
  input  logic [TotalWidth-1:0] corOut,
  input  logic [ ProtWidth-1:0] corSyndrome,
  input  logic                  corSingle,
  input  logic                  corDouble
);

  // Stage 1 covers the array read, stage 2 holds the registered response
  rspKindE               s1Kind;
  rspKindE               s2Kind;
  logic [ AddrWidth-1:0] s1Addr;
  logic [ AddrWidth-1:0] s2Addr;
  // Corrected codeword waiting to be scrubbed back
  logic [TotalWidth-1:0] wbCode;
  logic                  wbReq;
  logic                  s1Read;

  assign encData = reqWdata;
  assign corIn   = mem.memRdata;
  assign s1Read  = (s1Kind == rspRead);

  // A corrected response claims the array in its own cycle
  assign wbReq = (s2Kind == rspWriteBack);

  // Array port mux, a live request always takes priority
  // A write-back that collides with a request is simply lost
  always_comb begin
    mem.memEn    = 1'b0;
    mem.memWe    = 1'b0;
    mem.memAddr  = reqAddr;
    mem.memWdata = encCode ^ reqFlip;
    if (reqValid) begin
      mem.memEn = 1'b1;
      mem.memWe = reqWrite;
    end else if (wbReq) begin
      mem.memEn    = 1'b1;
      mem.memWe    = 1'b1;
      mem.memAddr  = s2Addr;
      mem.memWdata = wbCode;
    end
  end

  // Pipeline tags and response flags
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      s1Kind    <= rspIdle;
      s2Kind    <= rspIdle;
      rspSingle <= 1'b0;
      rspDouble <= 1'b0;
    end else begin
      s1Kind <= (reqValid && !reqWrite) ? rspRead : rspIdle;
      // Corrected reads are tagged so the next cycle issues the scrub
      if (s1Read) begin
        s2Kind <= corSingle ? rspWriteBack : rspRead;
      end else begin
        s2Kind <= rspIdle;
      end
      rspSingle <= s1Read & corSingle;
      rspDouble <= s1Read & corDouble;
    end
  end

  // Addresses and data ride along without reset
  always_ff @(posedge clk) begin
    s1Addr <= reqAddr;
    s2Addr <= s1Addr;
    if (s1Read) begin
      rspData     <= corOut[DataWidth-1:0];
      rspSyndrome <= corSyndrome;
      wbCode      <= corOut;
    end
  end

  assign rspValid = (s2Kind != rspIdle);

  // Counters update together with the response, so they already hold
  // the new value while rspValid is high, and stop at all ones
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      corrCount   <= '0;
      uncorrCount <= '0;
    end else begin
      if (s1Read && corSingle && corrCount != '1) begin
        corrCount <= corrCount + 1'b1;
      end
      if (s1Read && corDouble && uncorrCount != '1) begin
        uncorrCount <= uncorrCount + 1'b1;
      end
    end
  end

endmodule

//--- design/eccSram.sv
module eccSram #(
  parameter int unsigned TotalWidth = 39,
  parameter int unsigned AddrWidth = 4
) (
  input logic   clk,
  eccMemIf.mem  mem
);

  localparam int unsigned Depth = 2 ** AddrWidth;

  // Codeword storage, one entry per address
  // Contents are undefined until written, the same as a real macro
  logic [TotalWidth-1:0] storage [Depth];

  // Writes land at the clock edge of the access
  always_ff @(posedge clk) begin
    if (mem.memEn && mem.memWe) begin
      storage[mem.memAddr] <= mem.memWdata;
    end
  end

  // Reads register the addressed entry, so data shows up one cycle later
  // During a write the read port is left alone and keeps its last value
  always_ff @(posedge clk) begin
    if (mem.memEn && !mem.memWe) begin
      mem.memRdata <= storage[mem.memAddr];
    end
  end

endmodule

//--- design/hsiaoEccCor.sv
module hsiaoEccCor
  import hsiaoEccPkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7,
  localparam int unsigned TotalWidth = DataWidth + ProtWidth
) (
  input  logic [TotalWidth-1:0] in,
  output logic [TotalWidth-1:0] out,
  output logic [ ProtWidth-1:0] syndrome,
  output logic                  errSingle,
  output logic                  errDouble
);

  // Same matrix as the encoder, plus its column view for bit matching
  localparam hsiaoRowsT HsiaoRows = hsiaoMatrix(DataWidth, ProtWidth);
  localparam hsiaoColsT HsiaoCols = transpose(HsiaoRows, ProtWidth, TotalWidth);

  if (ProtWidth < minProtWidth(DataWidth) || TotalWidth > MaxTotalWidth) begin : genWidthCheck
    $error("hsiaoEccCor: unsupported DataWidth/ProtWidth combination");
  end

  // Each syndrome bit rechecks one row over data and parity together
  // A clean codeword gives all zeros
  for (genvar i = 0; i < ProtWidth; i++) begin : genSyndrome
    assign syndrome[i] = ^(in & HsiaoRows[i][TotalWidth-1:0]);
  end

  // A single flipped bit leaves exactly its own column code as syndrome
  // Every column is distinct, so at most one bit matches and is flipped back
  for (genvar i = 0; i < TotalWidth; i++) begin : genCorrect
    assign out[i] = in[i] ^ (syndrome == HsiaoCols[i][ProtWidth-1:0]);
  end

  // All columns have odd weight, so one error gives an odd syndrome
  assign errSingle = ^syndrome;

  // Two errors cancel to an even but nonzero syndrome
  // Nothing is corrected in that case since no column can match
  assign errDouble = ~errSingle & (|syndrome);

endmodule

//--- design/hsiaoEccEnc.sv
module hsiaoEccEnc
  import hsiaoEccPkg::*;
#(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned ProtWidth = 7,
  localparam int unsigned TotalWidth = DataWidth + ProtWidth
) (
  input  logic [ DataWidth-1:0] in,
  output logic [TotalWidth-1:0] out
);

  // Parity-check matrix, built once at elaboration
  localparam hsiaoRowsT HsiaoRows = hsiaoMatrix(DataWidth, ProtWidth);

  // Catch widths the code cannot protect, or the package containers cannot hold
  if (ProtWidth < minProtWidth(DataWidth) || TotalWidth > MaxTotalWidth) begin : genWidthCheck
    $error("hsiaoEccEnc: unsupported DataWidth/ProtWidth combination");
  end

  // The code is systematic so data passes straight into the low bits
  assign out[DataWidth-1:0] = in;

  // Each check bit covers the data bits marked in its matrix row
  // The identity part of the row only touches the check bit itself and is skipped
  for (genvar i = 0; i < ProtWidth; i++) begin : genParity
    assign out[DataWidth+i] = ^(in & HsiaoRows[i][DataWidth-1:0]);
  end

endmodule

//--- design/eccMemIf.sv
interface eccMemIf #(
  parameter int unsigned TotalWidth = 39,
  parameter int unsigned AddrWidth = 4
);

  // Access strobe, with memWe choosing write over read
  logic                  memEn;
  logic                  memWe;
  logic [ AddrWidth-1:0] memAddr;
  // Full codewords in both directions
  logic [TotalWidth-1:0] memWdata;
  // Valid the cycle after a read access
  logic [TotalWidth-1:0] memRdata;

  // Controller side issues accesses and takes read data
  modport ctrl (
    output memEn,
    output memWe,
    output memAddr,
    output memWdata,
    input  memRdata
  );

  // Array side serves accesses
  modport mem (
    input  memEn,
    input  memWe,
    input  memAddr,
    input  memWdata,
    output memRdata
  );

endinterface

//--- design/hsiaoEccPkg.sv
package hsiaoEccPkg;

  // Upper bounds for the matrix containers shared by the encoder and corrector
  localparam int unsigned MaxProtWidth = 8;
  localparam int unsigned MaxDataWidth = 64;
  localparam int unsigned MaxTotalWidth = MaxDataWidth + MaxProtWidth;

  // Width of each saturating error counter
  localparam int unsigned CountWidth = 8;

  // Row-major matrix, one row per parity bit
  typedef logic [MaxProtWidth-1:0][MaxTotalWidth-1:0] hsiaoRowsT;
  // Column-major view, one syndrome code per codeword bit
  typedef logic [MaxTotalWidth-1:0][MaxProtWidth-1:0] hsiaoColsT;

  // Response state of the controller pipeline
  typedef enum logic [1:0] {
    rspIdle,
    rspRead,
    rspWriteBack
  } rspKindE;

  // Smallest number of check bits that still gives SECDED on dataWidth bits
  function automatic int unsigned minProtWidth(int unsigned dataWidth);
    return $clog2(dataWidth) + 2;
  endfunction

  // Builds the parity-check matrix column by column
  // Data columns take the lightest odd weight that is still free (3, then 5 ...),
  // and among those the code whose rows carry the fewest ones so far
  // Parity columns form the identity in the top bits of the codeword
  function automatic hsiaoRowsT hsiaoMatrix(int unsigned dataWidth, int unsigned protWidth);
    hsiaoRowsT rows;
    int unsigned rowLoad [MaxProtWidth];
    logic [(1 << MaxProtWidth)-1:0] taken;
    logic [MaxProtWidth-1:0] cand;
    int unsigned weight;
    int unsigned cost;
    int unsigned bestCode;
    int unsigned bestCost;
    int unsigned bestWeight;
    rows = '0;
    taken = '0;
    for (int r = 0; r < MaxProtWidth; r++) begin
      rowLoad[r] = 0;
    end
    for (int col = 0; col < dataWidth; col++) begin
      bestCode = 0;
      bestCost = 32'hffff_ffff;
      bestWeight = 32'hffff_ffff;
      for (int code = 1; code < (1 << protWidth); code++) begin
        cand = code[MaxProtWidth-1:0];
        weight = $countones(cand);
        cost = 0;
        for (int r = 0; r < protWidth; r++) begin
          if (cand[r]) cost += rowLoad[r];
        end
        // Only odd weights of three or more keep singles and doubles apart
        if (weight >= 3 && weight[0] && !taken[code]) begin
          if (weight < bestWeight || (weight == bestWeight && cost < bestCost)) begin
            bestCode = code;
            bestCost = cost;
            bestWeight = weight;
          end
        end
      end
      taken[bestCode] = 1'b1;
      cand = bestCode[MaxProtWidth-1:0];
      for (int r = 0; r < protWidth; r++) begin
        if (cand[r]) begin
          rows[r][col] = 1'b1;
          rowLoad[r]++;
        end
      end
    end
    for (int p = 0; p < protWidth; p++) begin
      rows[p][dataWidth+p] = 1'b1;
    end
    return rows;
  endfunction

  // Turns rows into per-bit column codes so the corrector can compare syndromes
  function automatic hsiaoColsT transpose(hsiaoRowsT rows, int unsigned protWidth,
                                          int unsigned totalWidth);
    hsiaoColsT cols;
    cols = '0;
    for (int r = 0; r < protWidth; r++) begin
      for (int c = 0; c < totalWidth; c++) begin
        cols[c][r] = rows[r][c];
      end
    end
    return cols;
  endfunction

endpackage
